// File: hdl/conv_pkg.sv
/* shared widths and register map of the convolution engine
   memory request, stream flag and AXI4-Lite channel structs */
package conv_pkg;

   localparam int sample_w = 16;  // samples and weights
   localparam int nb_taps  = 9;
   localparam int sum_w    = 36;  // accumulator
   localparam int word_w   = 32;  // memory and bus data
   localparam int mem_aw   = 8;   // scratch word address
   localparam int addr_w   = 16;  // host byte address

   // host register map, byte offsets
   localparam logic [addr_w-1:0] ctrl_off   = 16'h0000; // bit 0 start, bit 1 signed
   localparam logic [addr_w-1:0] status_off = 16'h0004; // bit 0 busy, bit 1 done
   localparam logic [addr_w-1:0] desc_off   = 16'h0008; // src, dst, length bytes
   localparam logic [addr_w-1:0] weight_off = 16'h0010; // nine words
   localparam logic [addr_w-1:0] mem_off    = 16'h0400; // scratch window

   typedef struct packed {
      logic first;
      logic last;
   } stream_flags_t;

   typedef struct packed {
      logic              valid;
      logic              write;
      logic [mem_aw-1:0] addr;
      logic [word_w-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic              awvalid;
      logic [addr_w-1:0] awaddr;
      logic              wvalid;
      logic [word_w-1:0] wdata;
      logic              bready;
      logic              arvalid;
      logic [addr_w-1:0] araddr;
      logic              rready;
   } axil_req_t;

   typedef struct packed {
      logic              awready;
      logic              wready;
      logic              bvalid;
      logic [1:0]        bresp;   // always OKAY
      logic              arready;
      logic              rvalid;
      logic [word_w-1:0] rdata;
      logic [1:0]        rresp;   // always OKAY
   } axil_rsp_t;

endpackage

// File: hdl/conv_sop.sv
/* sum-of-products pipeline, nine taps with skewed input registers
   valid and flags delay line, global stall and clear */
module conv_sop #(
   parameter int DSP_REGS = 2  // input register depth
) (
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   input  logic                                                  enable,
   input  logic                                                  clear,
   input  logic                                                  valid_in,
   input  conv_pkg::stream_flags_t                               flags_in,
   output logic                                                  ready_in,
   input  logic                                                  signed_mode,
   input  logic [conv_pkg::nb_taps-1:0][conv_pkg::sample_w-1:0]  window,
   input  logic [conv_pkg::nb_taps-1:0][conv_pkg::sample_w-1:0]  weights,
   output logic                                                  valid_out,
   output conv_pkg::stream_flags_t                               flags_out,
   input  logic                                                  ready_out,
   output logic [conv_pkg::sum_w-1:0]                            y
);
   localparam int skew_d = DSP_REGS + conv_pkg::nb_taps - 1; // tap i waits i extra stages
   localparam int pipe_d = DSP_REGS + conv_pkg::nb_taps + 1; // input to y

   logic adv;
   logic [skew_d-1:0][conv_pkg::sample_w-1:0] x_pipe [conv_pkg::nb_taps];
   logic [skew_d-1:0][conv_pkg::sample_w-1:0] w_pipe [conv_pkg::nb_taps];
   logic signed [conv_pkg::sum_w-1:0] mul [conv_pkg::nb_taps];
   logic signed [conv_pkg::sum_w-1:0] sum [conv_pkg::nb_taps];
   logic [pipe_d-1:0]                       valid_pipe;
   conv_pkg::stream_flags_t [pipe_d-1:0]    flags_pipe;

   assign adv      = ready_out && enable; // whole pipe moves or nothing does
   assign ready_in = ready_out;

   // 17x17 product, low byte dropped, sign extended to the accumulator
   function automatic logic signed [conv_pkg::sum_w-1:0] tap_mul(
      input logic [conv_pkg::sample_w-1:0] x,
      input logic [conv_pkg::sample_w-1:0] w,
      input logic                          sgn
   );
      logic signed [conv_pkg::sample_w:0]     xe;
      logic signed [conv_pkg::sample_w:0]     we;
      logic signed [2*conv_pkg::sample_w+1:0] p;
      xe = {sgn & x[conv_pkg::sample_w-1], x}; // zero ext in unsigned mode
      we = {sgn & w[conv_pkg::sample_w-1], w};
      p  = xe * we;
      return {{(conv_pkg::sum_w-2*conv_pkg::sample_w-2){p[2*conv_pkg::sample_w+1]}},
              p[2*conv_pkg::sample_w+1:8], 8'h00};
   endfunction

   for (genvar i = 0; i < conv_pkg::nb_taps; i++) begin : g_tap
      always_ff @(posedge clk) begin
         if (adv) begin
            x_pipe[i] <= {x_pipe[i][skew_d-2:0], window[i]};  // shift in at index 0
            w_pipe[i] <= {w_pipe[i][skew_d-2:0], weights[i]};
            mul[i]    <= tap_mul(x_pipe[i][DSP_REGS-1+i], w_pipe[i][DSP_REGS-1+i], signed_mode);
         end
      end

      if (i == 0) begin : g_head
         always_ff @(posedge clk) begin
            if (adv) sum[i] <= mul[i];
         end
      end else begin : g_chain
         always_ff @(posedge clk) begin
            if (adv) sum[i] <= sum[i-1] + mul[i]; // partial sum one tap further
         end
      end
   end

   // control delay line, cleared on job start
   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         valid_pipe <= '0;
         flags_pipe <= '0;
      end else if (adv) begin
         valid_pipe <= {valid_pipe[pipe_d-2:0], valid_in};
         flags_pipe <= {flags_pipe[pipe_d-2:0], flags_in};
      end
   end

   assign valid_out = valid_pipe[pipe_d-1] && !clear;
   assign flags_out = flags_pipe[pipe_d-1];
   assign y         = sum[conv_pkg::nb_taps-1];

endmodule

// File: hdl/conv_regfile.sv
/* AXI4-Lite slave with control, status, descriptor and weight registers
   and the host window onto the scratch memory */
module conv_regfile #(
   parameter int MEM_DEPTH = 256
) (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  conv_pkg::axil_req_t                                  axil_req,
   output conv_pkg::axil_rsp_t                                  axil_rsp,
   output conv_pkg::mem_req_t                                   host_req,
   input  logic                                                 host_gnt,
   input  logic [conv_pkg::word_w-1:0]                          mem_rdata,
   output logic signed [conv_pkg::nb_taps-1:0][conv_pkg::sample_w-1:0] weights,
   output logic                                                 signed_mode,
   output logic [conv_pkg::mem_aw-1:0]                          src_base,
   output logic [conv_pkg::mem_aw-1:0]                          dst_base,
   output logic [conv_pkg::mem_aw-1:0]                          length,
   output logic                                                 start,
   output logic                                                 busy,
   input  logic                                                 done
);
   localparam logic [conv_pkg::addr_w-1:0] mem_end =
      conv_pkg::mem_off + conv_pkg::addr_w'(4 * MEM_DEPTH);

   logic idle, wr_acc, rd_acc, wr_mem, rd_mem;
   logic bvalid_q, rvalid_q, rd_wait, done_q;
   logic mreq_valid, mreq_write;
   logic [conv_pkg::mem_aw-1:0] mreq_addr;
   logic [conv_pkg::word_w-1:0] mreq_wdata, rdata_q, reg_rdata;
   logic [23:0] desc;

   // one access in flight at a time
   assign idle   = !mreq_valid && !rd_wait && !bvalid_q && !rvalid_q;
   assign wr_acc = idle && axil_req.awvalid && axil_req.wvalid;
   assign rd_acc = idle && axil_req.arvalid && !wr_acc; // writes first
   assign wr_mem = axil_req.awaddr >= conv_pkg::mem_off && axil_req.awaddr < mem_end;
   assign rd_mem = axil_req.araddr >= conv_pkg::mem_off && axil_req.araddr < mem_end;

   assign axil_rsp = '{awready: wr_acc, wready: wr_acc, bvalid: bvalid_q, bresp: 2'b00,
                       arready: rd_acc, rvalid: rvalid_q, rdata: rdata_q, rresp: 2'b00};
   assign host_req = '{valid: mreq_valid, write: mreq_write, addr: mreq_addr, wdata: mreq_wdata};

   assign src_base = desc[7:0];
   assign dst_base = desc[15:8];
   assign length   = desc[23:16];

   always_comb begin
      reg_rdata = '0;
      case (axil_req.araddr)
         conv_pkg::ctrl_off:   reg_rdata[1]    = signed_mode; // start reads as zero
         conv_pkg::status_off: reg_rdata[1:0]  = {done, busy};
         conv_pkg::desc_off:   reg_rdata[23:0] = desc;
         default: ;
      endcase
      for (int i = 0; i < conv_pkg::nb_taps; i++) begin
         if (axil_req.araddr == conv_pkg::weight_off + conv_pkg::addr_w'(4 * i))
            reg_rdata[conv_pkg::sample_w-1:0] = weights[i];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy        <= 1'b0;
         start       <= 1'b0;
         signed_mode <= 1'b0;
         bvalid_q    <= 1'b0;
         rvalid_q    <= 1'b0;
         mreq_valid  <= 1'b0;
         rd_wait     <= 1'b0;
         done_q      <= 1'b0;
      end else begin
         start  <= 1'b0;                          // single cycle pulse
         done_q <= done;
         if (done && !done_q) busy <= 1'b0;       // job finished
         if (axil_req.bready) bvalid_q <= 1'b0;
         if (axil_req.rready) rvalid_q <= 1'b0;
         if (mreq_valid && host_gnt) begin
            mreq_valid <= 1'b0;
            if (mreq_write) bvalid_q <= 1'b1;
            else rd_wait <= 1'b1;                 // rdata lands next cycle
         end
         if (rd_wait) begin
            rd_wait  <= 1'b0;
            rvalid_q <= 1'b1;
         end
         if (wr_acc) begin
            if (wr_mem) mreq_valid <= 1'b1;
            else bvalid_q <= 1'b1;
            if (axil_req.awaddr == conv_pkg::ctrl_off && !busy) begin // ignored mid job
               start       <= axil_req.wdata[0];
               busy        <= axil_req.wdata[0];
               signed_mode <= axil_req.wdata[1];
            end
         end
         if (rd_acc) begin
            if (rd_mem) mreq_valid <= 1'b1;
            else rvalid_q <= 1'b1;
         end
      end
   end

   // descriptor, weights and window request fields
   always_ff @(posedge clk) begin
      if (wr_acc) begin
         mreq_write <= 1'b1;
         mreq_addr  <= conv_pkg::mem_aw'((axil_req.awaddr - conv_pkg::mem_off) >> 2);
         mreq_wdata <= axil_req.wdata;
         if (axil_req.awaddr == conv_pkg::desc_off) desc <= axil_req.wdata[23:0];
         for (int i = 0; i < conv_pkg::nb_taps; i++) begin
            if (axil_req.awaddr == conv_pkg::weight_off + conv_pkg::addr_w'(4 * i))
               weights[i] <= axil_req.wdata[conv_pkg::sample_w-1:0];
         end
      end
      if (rd_acc) begin
         mreq_write <= 1'b0;
         mreq_addr  <= conv_pkg::mem_aw'((axil_req.araddr - conv_pkg::mem_off) >> 2);
         rdata_q    <= reg_rdata;
      end
      if (rd_wait) rdata_q <= mem_rdata;
   end

endmodule

// File: hdl/conv_mem_arbiter.sv
/* fixed-priority arbiter, host over store over fetch
   and the single-port scratch memory behind it */
module conv_mem_arbiter #(
   parameter int MEM_DEPTH = 256
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  conv_pkg::mem_req_t          host_req,
   input  conv_pkg::mem_req_t          store_req,
   input  conv_pkg::mem_req_t          fetch_req,
   output logic                        host_gnt,
   output logic                        store_gnt,
   output logic                        fetch_gnt,
   output logic [conv_pkg::word_w-1:0] rdata
);
   logic [conv_pkg::word_w-1:0] mem [MEM_DEPTH];
   conv_pkg::mem_req_t sel;

   assign host_gnt  = host_req.valid;
   assign store_gnt = store_req.valid && !host_req.valid;
   assign fetch_gnt = fetch_req.valid && !host_req.valid && !store_req.valid;

   always_comb begin
      if (host_gnt) sel = host_req;
      else if (store_gnt) sel = store_req;
      else sel = fetch_req;  // valid low when nobody asks
   end

   // one access per cycle, read data registered
   always_ff @(posedge clk) begin
      if (rst_n && sel.valid) begin
         if (sel.write) mem[sel.addr] <= sel.wdata;
         rdata <= mem[sel.addr]; // old word on a write
      end
   end

endmodule

// File: hdl/conv_fetch.sv
/* sample fetch, one read at a time through the arbiter
   into a nine-tap shift window with first and last flags */
module conv_fetch (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  logic                                                 start,
   input  logic [conv_pkg::mem_aw-1:0]                          src_base,
   input  logic [conv_pkg::mem_aw-1:0]                          length,
   output conv_pkg::mem_req_t                                   mem_req,
   input  logic                                                 mem_gnt,
   input  logic [conv_pkg::word_w-1:0]                          mem_rdata,
   input  logic                                                 advance_ready,
   output logic                                                 valid,
   output conv_pkg::stream_flags_t                              flags,
   output logic [conv_pkg::nb_taps-1:0][conv_pkg::sample_w-1:0] window
);
   localparam logic [conv_pkg::mem_aw-1:0] first_cnt = conv_pkg::mem_aw'(conv_pkg::nb_taps - 1);

   logic running, req_valid, rd_wait;
   logic [conv_pkg::mem_aw-1:0] rd_addr;
   logic [conv_pkg::mem_aw-1:0] got_cnt; // samples returned so far

   assign mem_req = '{valid: req_valid, write: 1'b0, addr: rd_addr, wdata: '0};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         running   <= 1'b0;
         req_valid <= 1'b0;
         rd_wait   <= 1'b0;
         valid     <= 1'b0;
         got_cnt   <= '0;
      end else if (start) begin
         running   <= 1'b1;
         req_valid <= 1'b0;
         rd_wait   <= 1'b0;
         valid     <= 1'b0;
         got_cnt   <= '0;
         rd_addr   <= src_base;
      end else begin
         rd_wait <= req_valid && mem_gnt;
         if (valid && advance_ready) valid <= 1'b0; // window taken
         if (req_valid && mem_gnt) begin
            req_valid <= 1'b0;
            rd_addr   <= rd_addr + 1'b1;
         end else if (running && !req_valid && !rd_wait && (!valid || advance_ready)) begin
            if (got_cnt == length) running <= 1'b0; // whole range read
            else req_valid <= 1'b1;
         end
         if (rd_wait) begin
            got_cnt <= got_cnt + 1'b1;
            if (got_cnt >= first_cnt) begin // window full from the ninth sample
               valid <= 1'b1;
               flags <= '{first: got_cnt == first_cnt, last: got_cnt + 1'b1 == length};
            end
         end
      end
   end

   // oldest sample at tap 0
   always_ff @(posedge clk) begin
      if (rd_wait)
         window <= {mem_rdata[conv_pkg::sample_w-1:0], window[conv_pkg::nb_taps-1:1]};
   end

endmodule

// File: hdl/conv_store.sv
/* two-entry result buffer, writes sums to the destination range
   and flags job completion after the last write */
module conv_store (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        start,
   input  logic [conv_pkg::mem_aw-1:0] dst_base,
   input  logic                        valid,
   input  conv_pkg::stream_flags_t     flags,
   input  logic [conv_pkg::sum_w-1:0]  sum,
   output logic                        ready,
   output conv_pkg::mem_req_t          mem_req,
   input  logic                        mem_gnt,
   output logic                        done
);
   logic [conv_pkg::word_w-1:0] data_q [2];
   logic [1:0] last_q;
   logic [1:0] count;
   logic wr_ptr, rd_ptr, push, pop;
   logic [conv_pkg::mem_aw-1:0] wr_addr;

   assign ready   = count != 2'd2;     // stalls the pipeline when full
   assign push    = valid && ready;
   assign pop     = mem_gnt;           // grant only while requesting
   assign mem_req = '{valid: count != 2'd0, write: 1'b1, addr: wr_addr, wdata: data_q[rd_ptr]};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count   <= '0;
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
         done    <= 1'b0;
         wr_addr <= '0;
      end else if (start) begin
         count   <= '0;
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
         done    <= 1'b0;
         wr_addr <= dst_base;
      end else begin
         if (push) wr_ptr <= !wr_ptr;
         if (pop) begin
            rd_ptr  <= !rd_ptr;
            wr_addr <= wr_addr + 1'b1;
            if (last_q[rd_ptr]) done <= 1'b1; // final result written
         end
         count <= count + 2'(push) - 2'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         data_q[wr_ptr] <= sum[conv_pkg::word_w-1:0]; // low 32 bits kept
         last_q[wr_ptr] <= flags.last;
      end
   end

endmodule

// File: hdl/conv_top.sv
/* convolution engine top, register file, arbiter,
   fetch, sum-of-products pipeline and result store */
module conv_top #(
   parameter int MEM_DEPTH = 256,
   parameter int DSP_REGS  = 2
) (
   input  logic                clk,
   input  logic                rst_n,
   input  conv_pkg::axil_req_t axil_req,
   output conv_pkg::axil_rsp_t axil_rsp
);
   conv_pkg::mem_req_t host_req, store_req, fetch_req;
   logic host_gnt, store_gnt, fetch_gnt;
   logic [conv_pkg::word_w-1:0] mem_rdata;
   logic signed [conv_pkg::nb_taps-1:0][conv_pkg::sample_w-1:0] weights;
   logic [conv_pkg::nb_taps-1:0][conv_pkg::sample_w-1:0] window;
   logic [conv_pkg::mem_aw-1:0] src_base, dst_base, length;
   logic signed_mode, start, busy, done;
   logic fetch_valid, sop_ready, sop_valid, store_ready;
   conv_pkg::stream_flags_t fetch_flags, sop_flags;
   logic [conv_pkg::sum_w-1:0] sop_y;

   conv_regfile #(.MEM_DEPTH(MEM_DEPTH)) u_regfile (
      .clk(clk), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
      .host_req(host_req), .host_gnt(host_gnt), .mem_rdata(mem_rdata),
      .weights(weights), .signed_mode(signed_mode), .src_base(src_base),
      .dst_base(dst_base), .length(length), .start(start), .busy(busy), .done(done)
   );

   conv_mem_arbiter #(.MEM_DEPTH(MEM_DEPTH)) u_arbiter (
      .clk(clk), .rst_n(rst_n), .host_req(host_req), .store_req(store_req),
      .fetch_req(fetch_req), .host_gnt(host_gnt), .store_gnt(store_gnt),
      .fetch_gnt(fetch_gnt), .rdata(mem_rdata)
   );

   conv_fetch u_fetch (
      .clk(clk), .rst_n(rst_n), .start(start), .src_base(src_base), .length(length),
      .mem_req(fetch_req), .mem_gnt(fetch_gnt), .mem_rdata(mem_rdata),
      .advance_ready(sop_ready), .valid(fetch_valid), .flags(fetch_flags), .window(window)
   );

   // runs only while busy, restarted by start
   conv_sop #(.DSP_REGS(DSP_REGS)) u_sop (
      .clk(clk), .rst_n(rst_n), .enable(busy), .clear(start), .valid_in(fetch_valid),
      .flags_in(fetch_flags), .ready_in(sop_ready), .signed_mode(signed_mode),
      .window(window), .weights(weights), .valid_out(sop_valid), .flags_out(sop_flags),
      .ready_out(store_ready), .y(sop_y)
   );

   conv_store u_store (
      .clk(clk), .rst_n(rst_n), .start(start), .dst_base(dst_base), .valid(sop_valid),
      .flags(sop_flags), .sum(sop_y), .ready(store_ready), .mem_req(store_req),
      .mem_gnt(store_gnt), .done(done)
   );

endmodule

// File: tests/conv_properties.sv
/* concurrent checks on arbiter grants and pipeline valid
   bound into the arbiter and the sum-of-products pipeline */
module conv_properties (
   input logic       clk,
   input logic       rst_n,
   input logic [2:0] gnt,       // host, store, fetch
   input logic [2:0] req,
   input logic       clear,
   input logic       valid_out
);

   grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
      else $error("more than one grant in a cycle, gnt %b", gnt);

   grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n) (gnt & ~req) == 3'b000)
      else $error("grant without request, gnt %b req %b", gnt, req);

   // delay line emptied by clear
   valid_low_on_clear: assert property (@(posedge clk) disable iff (!rst_n) clear |=> !valid_out)
      else $error("pipeline valid high in the cycle after clear");

endmodule

bind conv_mem_arbiter conv_properties u_arb_props (
   .clk(clk), .rst_n(rst_n),
   .gnt({host_gnt, store_gnt, fetch_gnt}),
   .req({host_req.valid, store_req.valid, fetch_req.valid}),
   .clear(1'b0), .valid_out(1'b0)   // no pipeline here
);

bind conv_sop conv_properties u_sop_props (
   .clk(clk), .rst_n(rst_n), .gnt(3'b000), .req(3'b000),
   .clear(clear), .valid_out(valid_out)
);

// File: tests/conv_tb.sv
/* testbench for the convolution engine, AXI4-Lite host tasks, job table
   reference model, compare tasks and cycle watchdog */
module conv_tb;

   localparam int nb_jobs = 4;
   localparam logic [1:0] okay_resp = 2'b00;

   typedef struct packed {
      logic [0:conv_pkg::nb_taps-1][conv_pkg::sample_w-1:0] w; // tap 0 first
      logic                                                 sgn;
      logic [conv_pkg::mem_aw-1:0]                          src;
      logic [conv_pkg::mem_aw-1:0]                          dst;
      logic [conv_pkg::mem_aw-1:0]                          len;
      logic [31:0]                                          seed;  // sample generator start
      logic [conv_pkg::mem_aw-1:0]                          n_out; // results expected
   } job_t;

   // signed, same data unsigned, minimal length, long unsigned
   job_t jobs [nb_jobs] = '{
      '{w: '{16'h0123, 16'hff80, 16'h7fff, 16'h8000, 16'h0001,
             16'hffff, 16'h3a5c, 16'hc3b1, 16'h0f0f},
        sgn: 1'b1, src: 8'h10, dst: 8'h60, len: 8'd24, seed: 32'd78, n_out: 8'd16},
      '{w: '{16'h0123, 16'hff80, 16'h7fff, 16'h8000, 16'h0001,
             16'hffff, 16'h3a5c, 16'hc3b1, 16'h0f0f},
        sgn: 1'b0, src: 8'h10, dst: 8'h80, len: 8'd24, seed: 32'd78, n_out: 8'd16},
      '{w: '{16'h0100, 16'hfe00, 16'h0300, 16'hfc00, 16'h0500,
             16'hfa00, 16'h0700, 16'hf800, 16'h0900},
        sgn: 1'b1, src: 8'ha0, dst: 8'hc0, len: 8'd9, seed: 32'd7801, n_out: 8'd1},
      '{w: '{16'h9e37, 16'h79b9, 16'h7f4a, 16'h7c15, 16'hbf58,
             16'h476d, 16'h1ce4, 16'he5b9, 16'h94d0},
        sgn: 1'b0, src: 8'h30, dst: 8'hd0, len: 8'd40, seed: 32'd7802, n_out: 8'd32}
   };

   logic                clk = 1'b0;
   logic                rst_n;
   conv_pkg::axil_req_t axil_req;
   conv_pkg::axil_rsp_t axil_rsp;
   logic [conv_pkg::sample_w-1:0] samples [256]; // current job's source data
   int mismatch_cnt = 0;
   int other_cnt    = 0;
   int cycle_cnt    = 0;

   conv_top #(.MEM_DEPTH(256), .DSP_REGS(2)) uut (
      .clk(clk), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // byte address of a scratch word in the host window
   function automatic logic [15:0] win_addr(input logic [conv_pkg::mem_aw-1:0] a);
      return conv_pkg::mem_off + {6'b0, a, 2'b00};
   endfunction

   function automatic logic [31:0] fill_word(input logic [7:0] a, input int j);
      return {8'h5a ^ 8'(j), a, ~a, a ^ 8'h3c};
   endfunction

   // sum of nine products with low bytes cleared and only the low 32 bits kept
   function automatic logic [31:0] expected_sum(input int j, input int k);
      longint acc;
      longint p;
      acc = 0;
      for (int i = 0; i < conv_pkg::nb_taps; i++) begin
         if (jobs[j].sgn)
            p = longint'($signed(samples[k + i])) * longint'($signed(jobs[j].w[i]));
         else
            p = longint'(samples[k + i]) * longint'(jobs[j].w[i]);
         acc += p & 64'hffff_ffff_ffff_ff00;
      end
      return acc[31:0];
   endfunction

   function automatic int watchdog_limit();
      int total;
      total = 2000;
      for (int j = 0; j < nb_jobs; j++) total += 200 * jobs[j].n_out;
      return total;
   endfunction

   task automatic check_word(input string name, input logic [conv_pkg::word_w-1:0] got,
                             input logic [conv_pkg::word_w-1:0] exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_status(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("mismatch at %0t: %s {done,busy} got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // both channels at once and bready held until the response is taken
   task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      axil_req.bready  = 1'b1;
      @(negedge clk);
      while (!axil_rsp.awready || !axil_rsp.wready) @(negedge clk); // sampled mid cycle
      @(posedge clk);
      #1;
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      @(negedge clk);
      while (!axil_rsp.bvalid) @(negedge clk);  // memory window waits for a grant
      check_resp("bresp", axil_rsp.bresp, okay_resp);
      @(posedge clk);
      #1;
      axil_req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
      @(posedge clk);
      #1;
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      axil_req.rready  = 1'b1;
      @(negedge clk);
      while (!axil_rsp.arready) @(negedge clk);
      @(posedge clk);
      #1;
      axil_req.arvalid = 1'b0;
      @(negedge clk);
      while (!axil_rsp.rvalid) @(negedge clk);
      data = axil_rsp.rdata;
      check_resp("rresp", axil_rsp.rresp, okay_resp);
      @(posedge clk);
      #1;
      axil_req.rready = 1'b0;
   endtask

   task automatic run_job(input int j);
      logic [31:0] rd;
      logic [31:0] st;
      logic [31:0] rng;
      logic [7:0]  lo_edge;
      logic [7:0]  hi_edge;
      rng     = jobs[j].seed;
      lo_edge = jobs[j].dst - 8'd1;           // words just outside the results
      hi_edge = jobs[j].dst + jobs[j].n_out;
      for (int k = 0; k < jobs[j].len; k++) begin
         rng = xorshift(rng);
         samples[k] = rng[15:0];
         axil_write(win_addr(jobs[j].src + 8'(k)), {16'h0000, rng[15:0]});
      end
      axil_write(win_addr(lo_edge), fill_word(lo_edge, j));
      axil_write(win_addr(hi_edge), fill_word(hi_edge, j));
      for (int i = 0; i < conv_pkg::nb_taps; i++)
         axil_write(conv_pkg::weight_off + 16'(4 * i), {16'h0000, jobs[j].w[i]});
      for (int i = 0; i < conv_pkg::nb_taps; i++) begin
         axil_read(conv_pkg::weight_off + 16'(4 * i), rd);
         check_word($sformatf("weight[%0d]", i), rd, {16'h0000, jobs[j].w[i]});
      end
      axil_write(conv_pkg::desc_off, {8'h00, jobs[j].len, jobs[j].dst, jobs[j].src});
      axil_write(conv_pkg::ctrl_off, {30'h0, jobs[j].sgn, 1'b1});
      axil_read(conv_pkg::status_off, st);
      check_status("status after start", st[1:0], 2'b01); // old done cleared
      // host traffic fighting the fetch and store for the memory
      for (int k = 0; k < 4; k++)
         axil_write(win_addr(8'hf8 + 8'(k)), fill_word(8'hf8 + 8'(k), j));
      for (int k = 0; k < 4; k++) begin
         axil_read(win_addr(8'hf8 + 8'(k)), rd);
         check_word("scratch word during job", rd, fill_word(8'hf8 + 8'(k), j));
      end
      axil_read(conv_pkg::status_off, st);
      while (!st[1]) begin
         check_status("status while running", st[1:0], 2'b01);
         axil_read(conv_pkg::status_off, st);
      end
      axil_read(conv_pkg::status_off, st);
      check_status("status after done", st[1:0], 2'b10);
      for (int k = 0; k < jobs[j].n_out; k++) begin
         axil_read(win_addr(jobs[j].dst + 8'(k)), rd);
         check_word($sformatf("job %0d result %0d", j, k), rd, expected_sum(j, k));
      end
      axil_read(win_addr(lo_edge), rd);
      check_word("word below results", rd, fill_word(lo_edge, j));
      axil_read(win_addr(hi_edge), rd);
      check_word("word above results", rd, fill_word(hi_edge, j));
   endtask

   // watchdog sized from the job table
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > watchdog_limit()) begin
         other_cnt++;
         $display("run timed out after %0d cycles before the job table finished", cycle_cnt);
         $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      logic [31:0] rd;
      rst_n    = 1'b0;
      axil_req = '0;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      axil_read(conv_pkg::status_off, rd);
      check_word("status after reset", rd, 32'h0);
      for (int j = 0; j < nb_jobs; j++) run_job(j);
      $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: src.f
hdl/conv_pkg.sv
hdl/conv_sop.sv
hdl/conv_regfile.sv
hdl/conv_mem_arbiter.sv
hdl/conv_fetch.sv
hdl/conv_store.sv
hdl/conv_top.sv
tests/conv_properties.sv
tests/conv_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = conv_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard hdl/*.sv tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
